/* sd_rx_pkg.sv */
package sd_rx_pkg;

  // Block geometry, kept small for simulation
  localparam int unsigned sd_block_bytes = 16;
  localparam int unsigned sd_data_bits = sd_block_bytes * 8;
  localparam int unsigned sd_crc_bits = 16;
  localparam int unsigned sd_count_bits = 8;

  // Frame lengths minus one, start bit included
  localparam logic [sd_count_bits-1:0] sd_len_r1 = 8'd7;
  localparam logic [sd_count_bits-1:0] sd_len_r2 = 8'd15;
  localparam logic [sd_count_bits-1:0] sd_len_r3 = 8'd39;
  localparam logic [sd_count_bits-1:0] sd_len_token = 8'd7;
  localparam logic [sd_count_bits-1:0] sd_len_block =
    sd_count_bits'(sd_data_bits + sd_crc_bits - 1);

  // Response kinds requested by the controller
  typedef enum logic [2:0] {
    resp_r1    = 3'b000,
    resp_r3_r7 = 3'b001,
    resp_token = 3'b010,
    resp_block = 3'b011,
    resp_r2    = 3'b100
  } sd_resp_t;

  // Receiver FSM states
  typedef enum logic [1:0] {
    st_idle       = 2'b00,
    st_wait_start = 2'b01,
    st_receive    = 2'b10,
    st_wait_busy  = 2'b11
  } sd_state_t;

  // Per-clock control from the FSM to the datapath
  typedef struct packed {
    logic start;  // new frame, start bit on miso now
    logic shift;  // sample miso this clock
  } sd_rx_ctrl_t;

endpackage

/* sd_bit_counter.sv */
module sd_bit_counter import sd_rx_pkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  input  sd_rx_ctrl_t              ctrl,
  input  sd_resp_t                 response_type,
  output logic [sd_count_bits-1:0] bits_left
);

  logic [sd_count_bits-1:0] frame_len;

  // Bits still to come after the start bit
  always_comb begin
    case (response_type)
      resp_r1:    frame_len = sd_len_r1;
      resp_r3_r7: frame_len = sd_len_r3;
      resp_token: frame_len = sd_len_token;
      resp_block: frame_len = sd_len_block;
      default:    frame_len = sd_len_r2;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      bits_left <= '0;
    end else if (ctrl.start) begin
      bits_left <= frame_len;
    end else if (ctrl.shift) begin
      bits_left <= bits_left - 1'b1;
    end
  end

  // FSM must stop shifting once the frame is exhausted
  a_no_underflow : assert property (
    @(posedge clock) disable iff (reset)
    (ctrl.shift && !ctrl.start) |-> (bits_left != '0)
  );

endmodule

/* sd_shift_capture.sv */
module sd_shift_capture import sd_rx_pkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  input  sd_rx_ctrl_t              ctrl,
  input  sd_resp_t                 response_type,
  input  logic [sd_count_bits-1:0] bits_left,
  input  logic                     miso,
  output logic [sd_data_bits-1:0]  received_data
);

  logic in_crc;
  logic capture_en;

  // The counter still holds the bit being sampled, so the
  // trailing CRC bits arrive while bits_left is 16 down to 1
  assign in_crc = (response_type == resp_block) &&
                  (bits_left <= sd_count_bits'(sd_crc_bits));

  assign capture_en = ctrl.shift && !in_crc;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      received_data <= '0;
    end else if (ctrl.start) begin
      // Fresh frame, start bit lands in bit 0
      received_data <= {{(sd_data_bits-1){1'b0}}, miso};
    end else if (capture_en) begin
      received_data <= {received_data[sd_data_bits-2:0], miso};
    end
  end

endmodule

/* sd_crc16.sv */
module sd_crc16 import sd_rx_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  sd_rx_ctrl_t ctrl,
  input  logic        miso,
  output logic        crc_zero
);

  logic [sd_crc_bits-1:0] crc;

  // One step of the CCITT LFSR, x^16 + x^12 + x^5 + 1
  function automatic logic [sd_crc_bits-1:0] crc_step(
    input logic [sd_crc_bits-1:0] cur,
    input logic                   din
  );
    logic feedback;
    feedback = cur[sd_crc_bits-1] ^ din;
    crc_step = {cur[sd_crc_bits-2:0], 1'b0};
    if (feedback) begin
      crc_step = crc_step ^ 16'h1021;
    end
  endfunction

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      crc <= '0;
    end else if (ctrl.start) begin
      // Restart from zero and take the start bit in
      crc <= crc_step('0, miso);
    end else if (ctrl.shift) begin
      crc <= crc_step(crc, miso);
    end
  end

  // Payload followed by its own CRC leaves no remainder
  assign crc_zero = (crc == '0);

endmodule

/* sd_rx_fsm.sv */
module sd_rx_fsm import sd_rx_pkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     valid,
  input  logic                     miso,
  input  sd_resp_t                 response_type,
  input  logic [sd_count_bits-1:0] bits_left,
  input  logic                     crc_zero,
  output sd_rx_ctrl_t              ctrl,
  output logic                     ready,
  output logic                     crc_error
);

  sd_state_t state;
  sd_state_t state_next;
  logic      frame_done;

  // Last bit was taken on the previous edge
  assign frame_done = (state == st_receive) && (bits_left == '0);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    ctrl       = '0;
    case (state)
      st_idle: begin
        if (valid) begin
          if (!miso) begin
            ctrl.start = 1'b1;
            ctrl.shift = 1'b1;
            state_next = st_receive;
          end else begin
            state_next = st_wait_start;
          end
        end
      end
      st_wait_start: begin
        // Card idles high until it has the answer
        if (!miso) begin
          ctrl.start = 1'b1;
          ctrl.shift = 1'b1;
          state_next = st_receive;
        end
      end
      st_receive: begin
        if (bits_left == '0) begin
          if (response_type == resp_token) begin
            state_next = st_wait_busy;
          end else begin
            state_next = st_idle;
          end
        end else begin
          ctrl.shift = 1'b1;
        end
      end
      st_wait_busy: begin
        // Card holds miso low while programming
        if (miso) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  assign ready = (state == st_idle);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      crc_error <= 1'b0;
    end else if (ctrl.start) begin
      crc_error <= 1'b0;
    end else if (frame_done) begin
      crc_error <= (response_type == resp_block) && !crc_zero;
    end
  end

  // Controller holds the response kind until the frame is over
  a_type_stable : assert property (
    @(posedge clock) disable iff (reset)
    (state != st_idle) |-> $stable(response_type)
  );

endmodule

/* sd_receiver_top.sv */
module sd_receiver_top import sd_rx_pkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  input  sd_resp_t                response_type,
  input  logic                    valid,
  input  logic                    miso,
  output logic                    ready,
  output logic [sd_data_bits-1:0] received_data,
  output logic                    crc_error
);

  sd_rx_ctrl_t              ctrl;
  logic [sd_count_bits-1:0] bits_left;
  logic                     crc_zero;

  sd_rx_fsm sd_rx_fsm_inst (
    .clock         (clock),
    .reset         (reset),
    .valid         (valid),
    .miso          (miso),
    .response_type (response_type),
    .bits_left     (bits_left),
    .crc_zero      (crc_zero),
    .ctrl          (ctrl),
    .ready         (ready),
    .crc_error     (crc_error)
  );

  // Frame length tracking
  sd_bit_counter sd_bit_counter_inst (
    .clock         (clock),
    .reset         (reset),
    .ctrl          (ctrl),
    .response_type (response_type),
    .bits_left     (bits_left)
  );

  sd_shift_capture sd_shift_capture_inst (
    .clock         (clock),
    .reset         (reset),
    .ctrl          (ctrl),
    .response_type (response_type),
    .bits_left     (bits_left),
    .miso          (miso),
    .received_data (received_data)
  );

  // CRC runs over every bit, CRC field included
  sd_crc16 sd_crc16_inst (
    .clock    (clock),
    .reset    (reset),
    .ctrl     (ctrl),
    .miso     (miso),
    .crc_zero (crc_zero)
  );

endmodule

/* sd_receiver_tb.sv */
module sd_receiver_tb import sd_rx_pkg::*; ();

  typedef struct packed {
    sd_resp_t                kind;
    logic [sd_data_bits-1:0] payload;
    logic [7:0]              idle_bits;
    logic [7:0]              busy_cycles;
    logic                    corrupt_crc;
  } test_row_t;

  logic                    clock;
  logic                    reset;
  sd_resp_t                response_type;
  logic                    valid;
  logic                    miso;
  logic                    ready;
  logic [sd_data_bits-1:0] received_data;
  logic                    crc_error;

  test_row_t   test_table[$];
  logic [31:0] rand_state;
  logic        expected_crc_prev;
  int          cycle_count = 0;
  int          cycle_limit;

  sd_receiver_top sd_receiver_top_inst (
    .clock         (clock),
    .reset         (reset),
    .response_type (response_type),
    .valid         (valid),
    .miso          (miso),
    .ready         (ready),
    .received_data (received_data),
    .crc_error     (crc_error)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the receiver did not return ready within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Start bit is the payload MSB, so it is forced low
  function automatic logic [sd_data_bits-1:0] random_payload();
    logic [sd_data_bits-1:0] value;
    int w;
    value = '0;
    for (w = 0; w < sd_data_bits / 32; w++) begin
      rand_state = next_random(rand_state);
      value = {value[sd_data_bits-33:0], rand_state};
    end
    value[sd_data_bits-1] = 1'b0;
    return value;
  endfunction

  function automatic int frame_length(input sd_resp_t kind);
    case (kind)
      resp_r1, resp_token: return 8;
      resp_r2:             return 16;
      resp_r3_r7:          return 40;
      default:             return sd_data_bits + sd_crc_bits;
    endcase
  endfunction

  // Long division of payload * x^16 by x^16 + x^12 + x^5 + 1
  function automatic logic [sd_crc_bits-1:0] ccitt_remainder(
    input logic [sd_data_bits-1:0] payload
  );
    logic [sd_data_bits+sd_crc_bits-1:0] work;
    int i;
    work = {payload, 16'h0000};
    for (i = sd_data_bits + sd_crc_bits - 1; i >= sd_crc_bits; i--) begin
      if (work[i]) begin
        work[i -: 17] = work[i -: 17] ^ 17'h11021;
      end
    end
    return work[sd_crc_bits-1:0];
  endfunction

  // Whole frame as the card sends it, right-aligned, MSB first on the wire
  function automatic logic [sd_data_bits+sd_crc_bits-1:0] build_frame(input test_row_t row);
    logic [sd_crc_bits-1:0] crc;
    if (row.kind == resp_block) begin
      crc = ccitt_remainder(row.payload);
      crc[0] = crc[0] ^ row.corrupt_crc;
      return {row.payload, crc};
    end
    return {{sd_crc_bits{1'b0}}, row.payload};
  endfunction

  function automatic logic [sd_data_bits-1:0] expected_data(input test_row_t row);
    if (row.kind == resp_block) begin
      return row.payload;
    end
    return row.payload & ({sd_data_bits{1'b1}} >> (sd_data_bits - frame_length(row.kind)));
  endfunction

  task automatic check_data(input string name, input logic [sd_data_bits-1:0] expected,
                            input logic [sd_data_bits-1:0] actual);
    if (actual !== expected) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_cycles(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic add_row(input sd_resp_t kind, input logic [sd_data_bits-1:0] payload,
                         input int idle, input int busy, input logic corrupt);
    test_row_t row;
    row.kind = kind;
    row.payload = payload;
    row.idle_bits = 8'(idle);
    row.busy_cycles = 8'(busy);
    row.corrupt_crc = corrupt;
    test_table.push_back(row);
  endtask

  task automatic build_table();
    rand_state = 32'h11fab3ef;
    add_row(resp_r1, 128'h05, 0, 0, 1'b0);
    add_row(resp_r1, 128'h3c, 3, 0, 1'b0);
    add_row(resp_r2, 128'h01a5, 0, 0, 1'b0);
    add_row(resp_r3_r7, 128'h01_0000_01aa, 2, 0, 1'b0);
    add_row(resp_block, random_payload(), 0, 0, 1'b0);
    add_row(resp_block, random_payload(), 4, 0, 1'b1);
    // Error flag from the bad block must survive the idle bits
    add_row(resp_r1, 128'h00, 2, 0, 1'b0);
    add_row(resp_token, 128'h05, 1, 6, 1'b0);
    add_row(resp_token, 128'h0b, 0, 0, 1'b0);
    add_row(resp_block, random_payload(), 1, 0, 1'b0);
    add_row(resp_r3_r7, 128'h3f_00ff_8000, 0, 0, 1'b0);
  endtask

  // Card model for one row, with a stray request in mid-frame
  task automatic run_row(input test_row_t row);
    logic [sd_data_bits+sd_crc_bits-1:0] frame;
    logic                                crc_expected;
    int n;
    int idle;
    int total;
    int stray;
    int waited;
    int i;
    frame = build_frame(row);
    n = frame_length(row.kind);
    idle = int'(row.idle_bits);
    total = idle + n + int'(row.busy_cycles);
    stray = idle + n / 2;
    @(negedge clock);
    check_flag("ready", 1'b1, ready);
    check_flag("crc_error", expected_crc_prev, crc_error);
    response_type = row.kind;
    for (i = 0; i < total; i++) begin
      if (i > 0) begin
        @(negedge clock);
        check_flag("ready", 1'b0, ready);
        check_flag("crc_error", (i <= idle) ? expected_crc_prev : 1'b0, crc_error);
      end
      valid = (i == 0) || (i == stray);
      if (i < idle) begin
        miso = 1'b1;
      end else if (i < idle + n) begin
        miso = frame[n - 1 - (i - idle)];
      end else begin
        miso = 1'b0;
      end
    end
    @(negedge clock);
    check_flag("ready", 1'b0, ready);
    valid = 1'b0;
    miso = 1'b1;
    waited = 0;
    while (ready !== 1'b1) begin
      @(negedge clock);
      waited++;
    end
    if (idle == 0 && row.kind != resp_token) begin
      check_cycles("ready latency", n, total + waited - 1);
    end
    crc_expected = (row.kind == resp_block) && row.corrupt_crc;
    check_data("received_data", expected_data(row), received_data);
    check_flag("crc_error", crc_expected, crc_error);
    expected_crc_prev = crc_expected;
    repeat (2) begin
      @(negedge clock);
      check_flag("ready", 1'b1, ready);
    end
  endtask

  initial begin
    reset = 1'b1;
    valid = 1'b0;
    miso = 1'b1;
    response_type = resp_r1;
    expected_crc_prev = 1'b0;
    build_table();
    cycle_limit = 0;
    foreach (test_table[r]) begin
      cycle_limit += frame_length(test_table[r].kind) + int'(test_table[r].idle_bits) +
                     int'(test_table[r].busy_cycles) + 20;
    end
    repeat (10) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    check_flag("ready", 1'b1, ready);
    check_flag("crc_error", 1'b0, crc_error);
    check_data("received_data", '0, received_data);
    foreach (test_table[r]) begin
      run_row(test_table[r]);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* build.f */
sd_rx_pkg.sv
sd_bit_counter.sv
sd_shift_capture.sv
sd_crc16.sv
sd_rx_fsm.sv
sd_receiver_top.sv
sd_receiver_tb.sv

/* Makefile */
TOP = sd_receiver_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
